//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_pipelined_processor
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- source/alu_stage.sv
`timescale 1ns/1ns

module alu_stage
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    exec_if.sink  in,
    mem_if.source out,
    output logic  jump_taken,
    output word_t jump_target
);

    word_t result;

    always_comb begin
        case (in.op)
            op_add: begin
                result = in.operand_a + in.operand_b;
            end
            op_sub: begin
                result = in.operand_a - in.operand_b;
            end
            op_and: begin
                result = in.operand_a & in.operand_b;
            end
            op_or: begin
                result = in.operand_a | in.operand_b;
            end
            op_xor: begin
                result = in.operand_a ^ in.operand_b;
            end
            op_shl: begin
                result = in.operand_a << 1;
            end
            op_shr: begin
                result = in.operand_a >> 1;
            end
            op_ldi: begin
                result = in.operand_b;
            end
            op_ld, op_st: begin
                // base register plus offset gives the data address
                result = in.operand_a + in.operand_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // jz tests its register in operand_a, both jumps take the target from operand_b
    assign jump_taken  = in.valid &&
                         (in.op == op_jmp || (in.op == op_jz && in.operand_a == '0));
    assign jump_target = in.operand_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        out.op         <= in.op;
        out.result     <= result;
        out.store_data <= in.store_data;
        out.rd         <= in.rd;
        out.writes_reg <= in.writes_reg;
    end

    // a taken jump comes from a valid instruction and decode squashes the next one
    a_jump_squash: assert property (
        @(posedge clk) disable iff (reset) jump_taken |-> in.valid ##1 !in.valid
    );

endmodule

//--- source/cpu_pkg.sv
package cpu_pkg;

    // one data or instruction word
    typedef logic [15:0] word_t;

    // one of the eight general registers
    typedef logic [2:0] reg_addr_t;

    // codes 14 and 15 are not assigned and decode as a no-op
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_shl  = 4'd5,
        op_shr  = 4'd6,
        op_ldi  = 4'd7,
        op_ld   = 4'd8,
        op_st   = 4'd9,
        op_jmp  = 4'd10,
        op_jz   = 4'd11,
        op_halt = 4'd12,
        op_nop  = 4'd13
    } opcode_e;

    typedef enum logic {
        fetch_running = 1'b0,
        fetch_halted  = 1'b1
    } fetch_state_e;

    // instruction field positions
    localparam int opcode_msb = 15;
    localparam int opcode_lsb = 12;
    localparam int rd_msb     = 11;
    localparam int rd_lsb     = 9;
    localparam int rs_msb     = 8;
    localparam int rs_lsb     = 6;
    localparam int rt_msb     = 5;
    localparam int rt_lsb     = 3;
    // the 6-bit offset and the jump target share the low bits
    localparam int offset_msb = 5;
    localparam int offset_lsb = 0;
    localparam int imm_msb    = 8;
    localparam int imm_lsb    = 0;

endpackage

//--- source/decode_stage.sv
`timescale 1ns/1ns

module decode_stage
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  word_t     instr,
    input  logic      instr_valid,
    input  logic      jump_taken,
    input  logic      wb_valid,
    input  reg_addr_t wb_reg,
    input  word_t     wb_data,
    exec_if.source    out
);

    word_t     regs [8];

    opcode_e   op;
    reg_addr_t rd;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rb_addr;
    word_t     ra_value;
    word_t     rb_value;
    word_t     imm_value;
    word_t     offset_value;
    word_t     operand_b;
    logic      writes_reg;

    assign op = opcode_e'(instr[opcode_msb:opcode_lsb]);
    assign rd = instr[rd_msb:rd_lsb];
    assign rs = instr[rs_msb:rs_lsb];
    assign rt = instr[rt_msb:rt_lsb];

    // sign-extended immediate for ldi, zero-extended offset or target otherwise
    assign imm_value    = word_t'(signed'(instr[imm_msb:imm_lsb]));
    assign offset_value = word_t'(instr[offset_msb:offset_lsb]);

    // stores send the rd register out as data on the second read port
    assign rb_addr = (op == op_st) ? rd : rt;

    // write-through, so a read of the register being written sees wb_data
    always_comb begin
        ra_value = regs[rs];
        rb_value = regs[rb_addr];
        if (wb_valid && wb_reg == rs) begin
            ra_value = wb_data;
        end
        if (wb_valid && wb_reg == rb_addr) begin
            rb_value = wb_data;
        end
    end

    always_comb begin
        operand_b  = rb_value;
        writes_reg = 1'b0;
        case (op)
            op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr: begin
                writes_reg = 1'b1;
            end
            op_ldi: begin
                operand_b  = imm_value;
                writes_reg = 1'b1;
            end
            op_ld: begin
                operand_b  = offset_value;
                writes_reg = 1'b1;
            end
            op_st, op_jmp, op_jz: begin
                operand_b = offset_value;
            end
            op_halt, op_nop: begin
                operand_b = '0;
            end
            default: begin
                operand_b = '0;
            end
        endcase
    end

    // register 0 is an ordinary register
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_reg] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            // a jump in the ALU squashes the instruction held here
            out.valid <= instr_valid && !jump_taken;
        end
    end

    always_ff @(posedge clk) begin
        out.op         <= op;
        out.operand_a  <= ra_value;
        out.operand_b  <= operand_b;
        out.store_data <= rb_value;
        out.rd         <= rd;
        out.writes_reg <= writes_reg;
    end

endmodule

//--- source/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage
    import cpu_pkg::*;
#(
    parameter int imem_depth = 64
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  load_enable,
    input  word_t load_addr,
    input  word_t load_data,
    input  logic  jump_taken,
    input  word_t jump_target,
    output word_t instr,
    output logic  instr_valid,
    output logic  fetching_halt
);

    // addresses wrap at the depth, which is a power of two
    localparam int imem_aw = $clog2(imem_depth);

    word_t              imem [imem_depth];
    logic [imem_aw-1:0] pc;
    fetch_state_e       state;
    word_t              fetch_word;
    logic               fetch_is_halt;

    assign fetch_word    = imem[pc];
    assign fetch_is_halt = fetch_word[opcode_msb:opcode_lsb] == op_halt;
    assign fetching_halt = state == fetch_halted;

    // the load port writes whenever it is enabled, also while the core runs
    always_ff @(posedge clk) begin
        if (load_enable) begin
            imem[load_addr[imem_aw-1:0]] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= '0;
            state       <= fetch_running;
            instr_valid <= 1'b0;
        end else if (jump_taken) begin
            // a halt fetched behind the jump is squashed, so fetch resumes
            pc          <= jump_target[imem_aw-1:0];
            state       <= fetch_running;
            instr_valid <= 1'b0;
        end else if (state == fetch_running) begin
            pc          <= pc + imem_aw'(1);
            instr_valid <= 1'b1;
            if (fetch_is_halt) begin
                state <= fetch_halted;
            end
        end else begin
            instr_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch_running) begin
            instr <= fetch_word;
        end
    end

    a_instr_valid_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(instr_valid)
    );

endmodule

//--- source/memory_stage.sv
`timescale 1ns/1ns

module memory_stage
    import cpu_pkg::*;
#(
    parameter int dmem_depth = 64
) (
    input  logic      clk,
    input  logic      reset,
    mem_if.sink       in,
    output logic      wb_valid,
    output reg_addr_t wb_reg,
    output word_t     wb_data,
    output logic      halted
);

    localparam int dmem_aw = $clog2(dmem_depth);

    word_t              dmem [dmem_depth];
    logic [dmem_aw-1:0] addr;
    word_t              load_data;

    // the address wraps at the memory depth
    assign addr      = in.result[dmem_aw-1:0];
    assign load_data = dmem[addr];

    always_ff @(posedge clk) begin
        if (in.valid && in.op == op_st) begin
            dmem[addr] <= in.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            wb_valid <= in.valid && in.writes_reg;
            // halted stays up until the next reset
            if (in.valid && in.op == op_halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_reg  <= in.rd;
        wb_data <= (in.op == op_ld) ? load_data : in.result;
    end

    // only ALU operations, ldi and ld may reach the register file
    a_wb_from_writer: assert property (
        @(posedge clk) disable iff (reset)
        wb_valid |-> $past(in.op) inside {op_add, op_sub, op_and, op_or, op_xor,
                                          op_shl, op_shr, op_ldi, op_ld}
    );

endmodule

//--- source/pipe_if.sv
`timescale 1ns/1ns

// decoded instruction with its operands, from decode to the ALU
interface exec_if
    import cpu_pkg::*;
();
    logic      valid;
    opcode_e   op;
    word_t     operand_a;
    word_t     operand_b;
    word_t     store_data;
    reg_addr_t rd;
    logic      writes_reg;

    modport source (output valid, op, operand_a, operand_b, store_data, rd, writes_reg);
    modport sink   (input  valid, op, operand_a, operand_b, store_data, rd, writes_reg);
endinterface

// ALU result on its way to the data memory and writeback
interface mem_if
    import cpu_pkg::*;
();
    logic      valid;
    opcode_e   op;
    word_t     result;
    word_t     store_data;
    reg_addr_t rd;
    logic      writes_reg;

    modport source (output valid, op, result, store_data, rd, writes_reg);
    modport sink   (input  valid, op, result, store_data, rd, writes_reg);
endinterface

//--- source/pipelined_processor.sv
`timescale 1ns/1ns

module pipelined_processor
    import cpu_pkg::*;
#(
    parameter int imem_depth = 64,
    parameter int dmem_depth = 64
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      load_enable,
    input  word_t     load_addr,
    input  word_t     load_data,
    output logic      wb_valid,
    output reg_addr_t wb_reg,
    output word_t     wb_data,
    output logic      halted
);

    word_t instr;
    logic  instr_valid;
    logic  fetching_halt;
    logic  jump_taken;
    word_t jump_target;

    exec_if exec_bus ();
    mem_if  mem_bus ();

    fetch_stage #(
        .imem_depth (imem_depth)
    ) fetch0 (
        .clk           (clk),
        .reset         (reset),
        .load_enable   (load_enable),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .jump_taken    (jump_taken),
        .jump_target   (jump_target),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .fetching_halt (fetching_halt)
    );

    // the writeback bus feeds the register file and the top-level ports alike
    decode_stage decode0 (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .jump_taken  (jump_taken),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .out         (exec_bus.source)
    );

    alu_stage alu0 (
        .clk         (clk),
        .reset       (reset),
        .in          (exec_bus.sink),
        .out         (mem_bus.source),
        .jump_taken  (jump_taken),
        .jump_target (jump_target)
    );

    memory_stage #(
        .dmem_depth (dmem_depth)
    ) memory0 (
        .clk      (clk),
        .reset    (reset),
        .in       (mem_bus.sink),
        .wb_valid (wb_valid),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data),
        .halted   (halted)
    );

endmodule

//--- tb/tb_pipelined_processor.sv
`timescale 1ns/1ns

module tb_pipelined_processor
    import cpu_pkg::*;
();

    localparam int num_tests = 12;
    localparam int prog_len  = 16;

    logic      clk;
    logic      reset;
    logic      load_enable;
    word_t     load_addr;
    word_t     load_data;
    logic      wb_valid;
    reg_addr_t wb_reg;
    word_t     wb_data;
    logic      halted;

    // stimulus table, one row per test
    string     names [num_tests];
    word_t     progs [num_tests][prog_len];
    reg_addr_t exp_reg [num_tests];
    word_t     exp_val [num_tests];
    int        exp_wbs [num_tests];
    logic      ordered [num_tests];

    int          fill_pos;
    int          pass_count;
    int          fail_count;
    int unsigned lcg_state = 32717;

    pipelined_processor dut0 (
        .clk         (clk),
        .reset       (reset),
        .load_enable (load_enable),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .halted      (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [8:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[24:16];
    endfunction

    function automatic word_t make_instr(opcode_e op, logic [2:0] rd, logic [2:0] rs,
                                         logic [5:0] low6);
        return {op, rd, rs, low6};
    endfunction

    function automatic word_t ldi_instr(logic [2:0] rd, logic [8:0] imm);
        return make_instr(op_ldi, rd, imm[8:6], imm[5:0]);
    endfunction

    function automatic word_t sext9(logic [8:0] v);
        return {{7{v[8]}}, v};
    endfunction

    // result of a register operation as the instruction set defines it
    function automatic word_t alu_expect(opcode_e op, word_t a, word_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_shl:  return a << 1;
            default: return a >> 1;
        endcase
    endfunction

    task automatic begin_test(int t, string name, reg_addr_t rd, word_t value, int wbs);
        names[t]   = name;
        exp_reg[t] = rd;
        exp_val[t] = value;
        exp_wbs[t] = wbs;
        ordered[t] = 1'b0;
        fill_pos   = 0;
        // every word not written below stays a halt
        for (int i = 0; i < prog_len; i++) begin
            progs[t][i] = make_instr(op_halt, 3'd0, 3'd0, 6'd0);
        end
    endtask

    task automatic emit(int t, word_t w);
        progs[t][fill_pos] = w;
        fill_pos++;
    endtask

    task automatic build_table();
        opcode_e    alu_ops [7];
        logic [8:0] a;
        logic [8:0] b;
        logic [5:0] offset;
        word_t      nop;
        string      jz_name;
        alu_ops = '{op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr};
        nop     = make_instr(op_nop, 3'd0, 3'd0, 6'd0);
        // two operands, two nops so both writes land, then the operation into r3
        for (int k = 0; k < 7; k++) begin
            a = next_random();
            b = next_random();
            // every other test gets a negative first operand
            if (k % 2 == 0) begin
                a[8] = 1'b1;
            end
            begin_test(k, $sformatf("alu_%s", alu_ops[k].name()), 3'd3,
                       alu_expect(alu_ops[k], sext9(a), sext9(b)), 3);
            emit(k, ldi_instr(3'd1, a));
            emit(k, ldi_instr(3'd2, b));
            emit(k, nop);
            emit(k, nop);
            emit(k, make_instr(alu_ops[k], 3'd3, 3'd1, {3'd2, 3'd0}));
        end
        // store r2 at r1 plus offset, then read it back into r4
        a      = next_random() & 9'h01f;
        b      = next_random();
        offset = 6'(next_random());
        begin_test(7, "store_load", 3'd4, sext9(b), 3);
        emit(7, ldi_instr(3'd1, a));
        emit(7, ldi_instr(3'd2, b));
        emit(7, nop);
        emit(7, nop);
        emit(7, make_instr(op_st, 3'd2, 3'd1, offset));
        emit(7, make_instr(op_ld, 3'd4, 3'd1, offset));
        // the two words after the jump must never write back
        begin_test(8, "jump", 3'd5, 16'h0077, 1);
        emit(8, make_instr(op_jmp, 3'd0, 3'd0, 6'd3));
        emit(8, ldi_instr(3'd2, 9'h055));
        emit(8, ldi_instr(3'd3, 9'h066));
        emit(8, ldi_instr(3'd5, 9'h077));
        // jz on r1 goes to word 8, falling through reaches word 6
        for (int t = 9; t < 11; t++) begin
            if (t == 9) begin
                jz_name = "jz_taken";
            end else begin
                jz_name = "jz_not_taken";
            end
            begin_test(t, jz_name, 3'd2, (t == 9) ? 16'h0022 : 16'h0011, 2);
            emit(t, ldi_instr(3'd1, (t == 9) ? 9'h000 : 9'h005));
            emit(t, nop);
            emit(t, nop);
            emit(t, make_instr(op_jz, 3'd0, 3'd1, 6'd8));
            emit(t, nop);
            emit(t, nop);
            emit(t, ldi_instr(3'd2, 9'h011));
            emit(t, make_instr(op_halt, 3'd0, 3'd0, 6'd0));
            emit(t, ldi_instr(3'd2, 9'h022));
        end
        // seven independent loads in a row, one writeback per cycle
        begin_test(11, "back_to_back", 3'd7, 16'h0000, 7);
        ordered[11] = 1'b1;
        for (int r = 1; r < 8; r++) begin
            a = next_random();
            emit(11, ldi_instr(3'(r), a));
            exp_val[11] = sext9(a);
        end
    endtask

    task automatic run_test(int t);
        int    cycles;
        int    wb_count;
        int    last_wb_cycle;
        logic  seen;
        word_t seen_val;
        logic  ok;
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < prog_len; i++) begin
            load_enable = 1'b1;
            load_addr   = word_t'(i);
            load_data   = progs[t][i];
            @(negedge clk);
        end
        load_enable = 1'b0;
        repeat (4) @(negedge clk);
        reset         = 1'b0;
        cycles        = 0;
        wb_count      = 0;
        last_wb_cycle = 0;
        seen          = 1'b0;
        seen_val      = '0;
        ok            = 1'b1;
        while (!halted && cycles < 200) begin
            @(negedge clk);
            cycles++;
            if (wb_valid) begin
                // the halt itself writes nothing, so halted must trail the last writeback
                if (halted) begin
                    $display("test %s: writeback %0d to r%0d came while halted was high",
                             names[t], wb_count, wb_reg);
                    ok = 1'b0;
                end
                if (ordered[t] && wb_reg != reg_addr_t'(wb_count + 1)) begin
                    $display("CHECK FAILED %s: writeback %0d register expected r%0d, actual r%0d",
                             names[t], wb_count, wb_count + 1, wb_reg);
                    ok = 1'b0;
                end
                if (ordered[t] && wb_count > 0 && cycles != last_wb_cycle + 1) begin
                    $display("test %s: writeback %0d came %0d cycles after the one before",
                             names[t], wb_count, cycles - last_wb_cycle);
                    ok = 1'b0;
                end
                if (wb_reg == exp_reg[t]) begin
                    seen     = 1'b1;
                    seen_val = wb_data;
                end
                wb_count++;
                last_wb_cycle = cycles;
            end
        end
        if (!halted) begin
            $display("test %s: halted never rose", names[t]);
            ok = 1'b0;
        end
        if (wb_count != exp_wbs[t]) begin
            $display("CHECK FAILED %s: writebacks expected %0d, actual %0d",
                     names[t], exp_wbs[t], wb_count);
            ok = 1'b0;
        end
        if (!seen) begin
            $display("test %s: r%0d was never written back", names[t], exp_reg[t]);
            ok = 1'b0;
        end else if (seen_val !== exp_val[t]) begin
            $display("CHECK FAILED %s: r%0d expected %h, actual %h",
                     names[t], exp_reg[t], exp_val[t], seen_val);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
            $display("test %s passed", names[t]);
        end else begin
            fail_count++;
            $display("test %s FAILED", names[t]);
        end
    endtask

    initial begin
        reset       = 1'b1;
        load_enable = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        pass_count  = 0;
        fail_count  = 0;
        build_table();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
source/cpu_pkg.sv
source/pipe_if.sv
source/fetch_stage.sv
source/decode_stage.sv
source/alu_stage.sv
source/memory_stage.sv
source/pipelined_processor.sv
tb/tb_pipelined_processor.sv
